//--- sources.f
hw/ufiBusPkg.sv
hw/ramPkg.sv
hw/syncFifo.sv
hw/ramReadWriteArbiter.sv
hw/ramPortUnit.sv
hw/ramSubsystemTop.sv
sim/tbRamSubsystem.sv

//--- Makefile
# Verilator build and run of the RAM subsystem testbench

VERILATOR ?= verilator
TOP       ?= tbRamSubsystem
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJDIR)

//--- sim/tbRamSubsystem.sv
/*
 * Table driven testbench for the buffered RAM command path.
 * Model and constants assume the top level defaults: 4 blocks, 8 address bits, depth 16.
 * Table addresses stay below 256, so no upper address bits alias.
 */
`default_nettype none
`timescale 1ns/1ns

module tbRamSubsystem;

	import ufiBusPkg::*;

	localparam int NUM_BLOCKS     = 4;
	localparam int RAM_DEPTH_LOG2 = 8;
	localparam int FIFO_DEPTH     = 16;
	localparam int BURST_READS    = FIFO_DEPTH + 4;

	// One row of the stimulus table
	typedef struct packed {
		ufiCmd_e                       cmd;
		logic [UFI_BLOCK_ID_WIDTH-1:0] blockId;
		logic [UFI_RAM_ADRS_WIDTH-1:0] ramAdrs;
		logic [3:0]                    gap;
		logic [UFI_DQ_WIDTH-1:0]       wd;
		logic [UFI_DQ_WIDTH-1:0]       exp;
	} stepEntry_t;

	logic    iCLK;
	logic    rstN;
	ufiReq_t ufiReq;
	logic    ufiRdy;
	ufiRsp_t ufiRsp;

	// Table, names kept alongside
	stepEntry_t steps[$];
	string      stepNames[$];

	// Reference contents, last write per block and word
	logic [UFI_DQ_WIDTH-1:0] model [NUM_BLOCKS][2 ** RAM_DEPTH_LOG2];

	// Scoreboard of outstanding reads
	ufiRsp_t pendRsp[$];
	string   pendName[$];

	int          passCount  = 0;
	int          failCount  = 0;
	int          readCount  = 0;
	int          respCount  = 0;
	int          cycleCount = 0;
	int          cycleLimit = 0;
	int unsigned seedDummy;

	ramSubsystemTop u_dut (
		.iCLK(iCLK),
		.rstN(rstN),
		.ufiReq(ufiReq),
		.ufiRdy(ufiRdy),
		.ufiRsp(ufiRsp)
	);

	// 8 ns period
	always #4 iCLK = ~iCLK;

	// ----------------------------------------------------------
	// Check and table helpers
	// ----------------------------------------------------------
	task automatic checkValue(string name, logic [47:0] expected, logic [47:0] actual);
		if (expected === actual)
		begin
			passCount++;
			$display("PASS %s", name);
		end
		else
		begin
			failCount++;
			$display("ERR %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic addStep(string name, ufiCmd_e cmd, int blk, int adrs, int gap);
		stepEntry_t e;
		e.cmd     = cmd;
		e.blockId = UFI_BLOCK_ID_WIDTH'(blk);
		e.ramAdrs = UFI_RAM_ADRS_WIDTH'(adrs);
		e.gap     = 4'(gap);
		e.wd      = UFI_DQ_WIDTH'($urandom);
		e.exp     = '0;
		steps.push_back(e);
		stepNames.push_back(name);
	endtask

	// Walk the table in issue order, reads see every earlier write
	task automatic fillExpected();
		int blk;
		int word;
		for (int b = 0; b < NUM_BLOCKS; b++)
		begin
			for (int w = 0; w < 2 ** RAM_DEPTH_LOG2; w++)
			begin
				model[b][w] = '0;
			end
		end
		for (int i = 0; i < steps.size(); i++)
		begin
			blk  = int'(steps[i].blockId);
			word = int'(steps[i].ramAdrs[RAM_DEPTH_LOG2-1:0]);
			if (blk >= NUM_BLOCKS)
				steps[i].exp = '0;
			else if (steps[i].cmd == UFI_WRITE)
				model[blk][word] = steps[i].wd;
			else
				steps[i].exp = model[blk][word];
		end
	endtask

	// One strobe, held off while ufiRdy is low
	task automatic issueStep(int idx);
		ufiReq_t req;
		ufiRsp_t rsp;
		req.adrs.enable   = 1'b1;
		req.adrs.cmd      = steps[idx].cmd;
		req.adrs.reserved = 1'b0;
		req.adrs.blockId  = steps[idx].blockId;
		req.adrs.ramAdrs  = steps[idx].ramAdrs;
		req.wd            = steps[idx].wd;
		@(negedge iCLK);
		while (!ufiRdy)
		begin
			@(posedge iCLK);
			ufiReq <= '0;
			@(negedge iCLK);
		end
		@(posedge iCLK);
		ufiReq <= req;
		if (steps[idx].cmd == UFI_READ)
		begin
			// Address echoed with the valid bit set
			rsp.adrs = req.adrs;
			rsp.rd   = steps[idx].exp;
			pendRsp.push_back(rsp);
			pendName.push_back(stepNames[idx]);
			readCount++;
		end
		for (int g = 0; g < int'(steps[idx].gap); g++)
		begin
			@(posedge iCLK);
			ufiReq <= '0;
		end
	endtask

	// ----------------------------------------------------------
	// Response monitor, sampled mid cycle
	// ----------------------------------------------------------
	always @(negedge iCLK)
	begin
		if (ufiRsp.adrs.enable)
		begin
			respCount++;
			if (pendRsp.size() == 0)
			begin
				failCount++;
				$display("Read response arrived with no read outstanding, adrs %h",
					ufiRsp.adrs);
			end
			else
				checkValue(pendName.pop_front(), pendRsp.pop_front(), ufiRsp);
		end
	end

	// Run limit from the table length
	always @(posedge iCLK)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit != 0 && cycleCount >= cycleLimit)
		begin
			$display("Timeout after %0d cycles, %0d reads still unanswered",
				cycleCount, pendRsp.size());
			$display("Regression failed");
			$finish;
		end
	end

	// ----------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------
	initial
	begin
		iCLK   = 1'b0;
		rstN   = 1'b0;
		ufiReq = '0;
		seedDummy = $urandom(32'ha3de);

		// Write then read, single location
		addStep("wrA", UFI_WRITE, 0, 'h005, 2);
		addStep("rdA", UFI_READ, 0, 'h005, 3);
		// Back to back, read right after its write
		addStep("wrB", UFI_WRITE, 2, 'h0a0, 0);
		addStep("rdB", UFI_READ, 2, 'h0a0, 0);
		addStep("wrC", UFI_WRITE, 3, 'h011, 0);
		addStep("rdC", UFI_READ, 3, 'h011, 0);
		addStep("rdA2", UFI_READ, 0, 'h005, 4);
		// Same word, every block
		for (int b = 0; b < NUM_BLOCKS; b++)
			addStep($sformatf("wrBlk%0d", b), UFI_WRITE, b, 'h033, 1);
		for (int b = 0; b < NUM_BLOCKS; b++)
			addStep($sformatf("rdBlk%0d", b), UFI_READ, b, 'h033, (b == NUM_BLOCKS - 1) ? 4 : 0);
		// Missing blocks, block 5 shares select bits with block 1
		addStep("wrOob5", UFI_WRITE, 5, 'h033, 1);
		addStep("rdOob5", UFI_READ, 5, 'h033, 0);
		addStep("rdOob15", UFI_READ, 15, 'h033, 0);
		addStep("rdAlias1", UFI_READ, 1, 'h033, 0);
		addStep("rdOob4", UFI_READ, 4, 'h005, 4);
		// Burst longer than the FIFO depth
		for (int k = 0; k < BURST_READS; k++)
			addStep($sformatf("burst%0d", k), UFI_READ, k % NUM_BLOCKS,
				(k % 2) ? 'h033 : 'h0a0, 0);

		fillExpected();
		cycleLimit = 10 + 20 * steps.size() + 100;

		repeat (10) @(posedge iCLK);
		rstN <= 1'b1;

		// Idle bus after reset
		repeat (10) @(negedge iCLK);
		checkValue("rdyAfterReset", 48'(1), 48'(ufiRdy));

		for (int i = 0; i < steps.size(); i++)
			issueStep(i);
		@(posedge iCLK);
		ufiReq <= '0;

		// Drain, then look for stray strobes
		while (pendRsp.size() != 0)
			@(negedge iCLK);
		repeat (10) @(negedge iCLK);
		checkValue("responseCount", 48'(readCount), 48'(respCount));

		$display("Done: %0d passed, %0d failed", passCount, failCount);
		if (failCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/ramSubsystemTop.sv
/*
 * Bus command path into block RAM with in order execution.
 * pFifoDepth must be a power of two, pNumBlocks between 2 and 16.
 */
`default_nettype none
`timescale 1ns/1ns

module ramSubsystemTop #(
	parameter int pFifoDepth    = 16,
	parameter int pNumBlocks    = 4,
	parameter int pRamDepthLog2 = 8
)(
	input  wire                     iCLK,
	input  wire                     rstN,
	input  wire ufiBusPkg::ufiReq_t ufiReq,
	output logic                    ufiRdy,
	output ufiBusPkg::ufiRsp_t      ufiRsp
);

	import ramPkg::*;

	// Command toward the RAM, read word back
	ramCmd_t ramCmd;
	ramRsp_t ramRsp;

	// ----------------------------------------------------------
	// Command queues
	// ----------------------------------------------------------
	ramReadWriteArbiter #(
		.pFifoDepth(pFifoDepth)
	) u_arbiter (
		.iCLK(iCLK),
		.rstN(rstN),
		.ufiReq(ufiReq),
		.ufiRdy(ufiRdy),
		.ufiRsp(ufiRsp),
		.ramCmd(ramCmd),
		.ramRsp(ramRsp)
	);

	// ----------------------------------------------------------
	// RAM bank
	// ----------------------------------------------------------
	ramPortUnit #(
		.pNumBlocks(pNumBlocks),
		.pRamDepthLog2(pRamDepthLog2)
	) u_ramPort (
		.iCLK(iCLK),
		.rstN(rstN),
		.ramCmd(ramCmd),
		.ramRsp(ramRsp)
	);

endmodule

`default_nettype wire

//--- hw/ramPortUnit.sv
/*
 * Bank of pNumBlocks synchronous RAMs, 2 <= pNumBlocks <= 16.
 * Only the low pRamDepthLog2 address bits are decoded, upper bits alias.
 * Out of range blocks ignore writes and read back as zero.
 */
`default_nettype none
`timescale 1ns/1ns

module ramPortUnit #(
	parameter int pNumBlocks    = 4,
	parameter int pRamDepthLog2 = 8
)(
	input  wire                  iCLK,
	input  wire                  rstN,
	input  wire ramPkg::ramCmd_t ramCmd,
	output ramPkg::ramRsp_t      ramRsp
);

	import ufiBusPkg::*;

	localparam int lpRamWords = 2 ** pRamDepthLog2;
	localparam int lpBlkSelW  = $clog2(pNumBlocks);

	// ----------------------------------------------------------
	// Command decode
	// ----------------------------------------------------------
	logic [lpBlkSelW-1:0]     blkSel;
	logic [pRamDepthLog2-1:0] wordSel;
	logic                     blkInRange;
	logic                     wrValid;
	logic                     rdValid;

	assign blkSel  = ramCmd.adrs.blockId[lpBlkSelW-1:0];
	assign wordSel = ramCmd.adrs.ramAdrs[pRamDepthLog2-1:0];

	// Full ID compared, not just the select bits
	assign blkInRange = {1'b0, ramCmd.adrs.blockId}
		< (UFI_BLOCK_ID_WIDTH + 1)'(pNumBlocks);

	assign wrValid = ramCmd.adrs.enable && (ramCmd.adrs.cmd == UFI_WRITE);
	assign rdValid = ramCmd.adrs.enable && (ramCmd.adrs.cmd == UFI_READ);

	// ----------------------------------------------------------
	// RAM blocks
	// ----------------------------------------------------------
	logic [UFI_DQ_WIDTH-1:0] mem [pNumBlocks][lpRamWords];

	// Simulation starts from all zero contents
	initial
	begin
		for (int b = 0; b < pNumBlocks; b++)
		begin
			for (int w = 0; w < lpRamWords; w++)
			begin
				mem[b][w] = '0;
			end
		end
	end

	// Write, dropped for a missing block
	always @(posedge iCLK)
	begin
		if (wrValid && blkInRange)
			mem[blkSel][wordSel] <= ramCmd.wd;
	end

	// ----------------------------------------------------------
	// Read return
	// ----------------------------------------------------------
	logic [UFI_DQ_WIDTH-1:0] rspDq;
	logic                    rspWe;

	// Data word, held between reads
	always_ff @(posedge iCLK)
	begin
		if (rdValid)
			rspDq <= blkInRange ? mem[blkSel][wordSel] : '0;
	end

	// One strobe per read, one cycle later
	always_ff @(posedge iCLK or negedge rstN)
	begin
		if (!rstN)
			rspWe <= 1'b0;
		else
			rspWe <= rdValid;
	end

	assign ramRsp = '{we: rspWe, dq: rspDq};

endmodule

`default_nettype wire

//--- hw/ramReadWriteArbiter.sv
/*
 * Queues bus commands toward the RAM and rejoins read data with its address.
 * No back-pressure on responses, the master must honor ufiRdy before a strobe.
 * Read data must return in command order, one word per read.
 */
`default_nettype none
`timescale 1ns/1ns

module ramReadWriteArbiter #(
	parameter int pFifoDepth = 16
)(
	input  wire                      iCLK,
	input  wire                      rstN,
	input  wire ufiBusPkg::ufiReq_t  ufiReq,
	output logic                     ufiRdy,
	output ufiBusPkg::ufiRsp_t       ufiRsp,
	output ramPkg::ramCmd_t          ramCmd,
	input  wire ramPkg::ramRsp_t     ramRsp
);

	import ufiBusPkg::*;

	// Address word minus the enable bit
	localparam int lpAdrsBodyW = UFI_ADRS_WIDTH - 1;

	// ----------------------------------------------------------
	// Write side FIFO pair
	// ----------------------------------------------------------
	logic                   wrDqFull;
	logic                   wrAdrsFull;
	logic                   wrDqEmp;
	logic                   wrPop;
	logic                   wrAdrsRvd;
	logic [lpAdrsBodyW-1:0] wrAdrsRd;

	// Drain toward the RAM whenever anything is queued
	assign wrPop = ~wrDqEmp;

	syncFifo #(
		.pFifoDepth(pFifoDepth),
		.pWidth(UFI_DQ_WIDTH)
	) wrDqFifo (
		.iCLK(iCLK),
		.rstN(rstN),
		.wd(ufiReq.wd),
		.we(ufiReq.adrs.enable),
		.full(wrDqFull),
		.rd(ramCmd.wd),
		.re(wrPop),
		.rvd(),
		.emp(wrDqEmp)
	);

	syncFifo #(
		.pFifoDepth(pFifoDepth),
		.pWidth(lpAdrsBodyW)
	) wrAdrsFifo (
		.iCLK(iCLK),
		.rstN(rstN),
		.wd(ufiReq.adrs[lpAdrsBodyW-1:0]),
		.we(ufiReq.adrs.enable),
		.full(wrAdrsFull),
		.rd(wrAdrsRd),
		.re(wrPop),
		.rvd(wrAdrsRvd),
		.emp()
	);

	// Read valid takes the place of the enable bit
	assign ramCmd.adrs = ufiAdrs_t'({wrAdrsRvd, wrAdrsRd});

	// ----------------------------------------------------------
	// Read side FIFO pair
	// ----------------------------------------------------------
	logic                   rdDqFull;
	logic                   rdAdrsFull;
	logic                   rdDqEmp;
	logic                   rdAdrsEmp;
	logic                   rdPop;
	logic                   rdAdrsPush;
	logic                   rdDqRvd;
	logic [lpAdrsBodyW-1:0] rdAdrsRd;

	// Only reads wait for a data word
	assign rdAdrsPush = ufiReq.adrs.enable && (ufiReq.adrs.cmd == UFI_READ);
	// Address is always queued before its data returns
	assign rdPop      = ~rdDqEmp;

	syncFifo #(
		.pFifoDepth(pFifoDepth),
		.pWidth(UFI_DQ_WIDTH)
	) rdDqFifo (
		.iCLK(iCLK),
		.rstN(rstN),
		.wd(ramRsp.dq),
		.we(ramRsp.we),
		.full(rdDqFull),
		.rd(ufiRsp.rd),
		.re(rdPop),
		.rvd(rdDqRvd),
		.emp(rdDqEmp)
	);

	syncFifo #(
		.pFifoDepth(pFifoDepth),
		.pWidth(lpAdrsBodyW)
	) rdAdrsFifo (
		.iCLK(iCLK),
		.rstN(rstN),
		.wd(ufiReq.adrs[lpAdrsBodyW-1:0]),
		.we(rdAdrsPush),
		.full(rdAdrsFull),
		.rd(rdAdrsRd),
		.re(rdPop),
		.rvd(),
		.emp(rdAdrsEmp)
	);

	assign ufiRsp.adrs = ufiAdrs_t'({rdDqRvd, rdAdrsRd});

	// Any full FIFO holds off the master
	assign ufiRdy = ~|{wrDqFull, wrAdrsFull, rdDqFull, rdAdrsFull};

	// ----------------------------------------------------------
	// Checks
	// ----------------------------------------------------------
	assert property (@(posedge iCLK) disable iff (!rstN) ufiReq.adrs.enable |-> ufiRdy)
		else $error("Bus strobe while ufiRdy low");

	// Returned data without a queued read address means an extra RAM response
	assert property (@(posedge iCLK) disable iff (!rstN) !rdDqEmp |-> !rdAdrsEmp)
		else $error("Read data with no pending read address");

endmodule

`default_nettype wire

//--- hw/syncFifo.sv
/*
 * Single clock FIFO, pFifoDepth must be a power of two.
 * rd and rvd update one cycle after a pop. full is a registered level.
 * No overflow or underflow protection, callers watch full and emp.
 */
`default_nettype none
`timescale 1ns/1ns

module syncFifo #(
	parameter int pFifoDepth = 16,
	parameter int pWidth     = 16
)(
	input  wire              iCLK,
	input  wire              rstN,
	input  wire [pWidth-1:0] wd,
	input  wire              we,
	output logic             full,
	output logic [pWidth-1:0] rd,
	input  wire              re,
	output logic             rvd,
	output logic             emp
);

	localparam int lpPtrW = $clog2(pFifoDepth);
	localparam int lpCntW = $clog2(pFifoDepth + 1);

	// ----------------------------------------------------------
	// Storage and pointers
	// ----------------------------------------------------------
	logic [pWidth-1:0] mem [pFifoDepth];
	logic [lpPtrW-1:0] wrPtr;
	logic [lpPtrW-1:0] rdPtr;
	logic [lpCntW-1:0] count;
	logic [lpCntW-1:0] countNext;

	// Occupancy after this edge
	always_comb
	begin
		case ({we, re})
			2'b10:   countNext = count + 1'b1;
			2'b01:   countNext = count - 1'b1;
			default: countNext = count;
		endcase
	end

	always_ff @(posedge iCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			full  <= 1'b0;
			rvd   <= 1'b0;
		end
		else
		begin
			// Pointers wrap naturally at a power of two depth
			if (we)
				wrPtr <= wrPtr + 1'b1;
			if (re)
				rdPtr <= rdPtr + 1'b1;
			count <= countNext;
			full  <= (countNext == lpCntW'(pFifoDepth));
			// Valid pulse trails the pop by one cycle
			rvd   <= re;
		end
	end

	// Write port
	always_ff @(posedge iCLK)
	begin
		if (we)
			mem[wrPtr] <= wd;
	end

	// Registered read port, holds last popped word
	always_ff @(posedge iCLK)
	begin
		if (re)
			rd <= mem[rdPtr];
	end

	// Count is registered, so emp only drops after the push edge
	assign emp = (count == '0);

	// ----------------------------------------------------------
	// Checks
	// ----------------------------------------------------------
	assert property (@(posedge iCLK) disable iff (!rstN) !(we && full))
		else $error("syncFifo push while full");

	assert property (@(posedge iCLK) disable iff (!rstN) !(re && emp))
		else $error("syncFifo pop while empty");

endmodule

`default_nettype wire

//--- hw/ramPkg.sv
/*
 * RAM side command and response records.
 * Commands arrive in bus order, one per cycle at most.
 */
`default_nettype none

package ramPkg;

	import ufiBusPkg::*;

	// ----------------------------------------------------------
	// Arbiter to RAM port unit
	// ----------------------------------------------------------

	// Popped from the write FIFO pair
	// adrs.enable is the FIFO read valid
	typedef struct packed {
		ufiAdrs_t                adrs;
		logic [UFI_DQ_WIDTH-1:0] wd;
	} ramCmd_t;

	// ----------------------------------------------------------
	// RAM port unit to arbiter
	// ----------------------------------------------------------

	// One we pulse per read command
	typedef struct packed {
		logic                    we;
		logic [UFI_DQ_WIDTH-1:0] dq;
	} ramRsp_t;

endpackage

`default_nettype wire

//--- hw/ufiBusPkg.sv
/*
 * Word bus definitions shared by the arbiter, RAM port unit and top.
 * Address bit 29 is reserved and carried through unchanged.
 * The enable bit doubles as the strobe on requests and the valid bit on responses.
 */
`default_nettype none

package ufiBusPkg;

	// ----------------------------------------------------------
	// Word widths
	// ----------------------------------------------------------

	// Data word on both directions
	localparam int UFI_DQ_WIDTH = 16;

	// Full address word including control bits
	localparam int UFI_ADRS_WIDTH = 32;

	// Block select field, bits 28 to 25
	localparam int UFI_BLOCK_ID_WIDTH = 4;

	// RAM word address field, bits 24 to 0
	localparam int UFI_RAM_ADRS_WIDTH = 25;

	// ----------------------------------------------------------
	// Command opcode and address layout
	// ----------------------------------------------------------

	// Bit 30 of the address word
	typedef enum logic {
		UFI_WRITE = 1'b0,
		UFI_READ  = 1'b1
	} ufiCmd_e;

	// MSB first, matches the bit assignment of the address word
	typedef struct packed {
		logic                          enable;
		ufiCmd_e                       cmd;
		logic                          reserved;
		logic [UFI_BLOCK_ID_WIDTH-1:0] blockId;
		logic [UFI_RAM_ADRS_WIDTH-1:0] ramAdrs;
	} ufiAdrs_t;

	// Master to slave, one strobe per command
	typedef struct packed {
		ufiAdrs_t                adrs;
		logic [UFI_DQ_WIDTH-1:0] wd;
	} ufiReq_t;

	// Slave to master, adrs.enable marks a valid read word
	typedef struct packed {
		ufiAdrs_t                adrs;
		logic [UFI_DQ_WIDTH-1:0] rd;
	} ufiRsp_t;

endpackage

`default_nettype wire
